// File: build.f
rtl/cpu_types_pkg.sv
rtl/cache_cfg_pkg.sv
rtl/data_cache.sv
rtl/line_memory.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/mem_wb_top.sv
dv/tb_mem_wb.sv

// File: Bender.yml
package:
  name: mem_wb

sources:
  - files:
      - rtl/cpu_types_pkg.sv
      - rtl/cache_cfg_pkg.sv
      - rtl/data_cache.sv
      - rtl/line_memory.sv
      - rtl/mem_stage.sv
      - rtl/wb_stage.sv
      - rtl/mem_wb_top.sv
  - target: test
    files:
      - dv/tb_mem_wb.sv

// File: dv/tb_mem_wb.sv
`timescale 1ns/1ps

module tb_mem_wb;
  import cpu_types_pkg::*;
  import cache_cfg_pkg::*;

  localparam int N_DIRECTED = 20;
  localparam int N_RANDOM   = 150;
  localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * 20 + 200;
  localparam int MEM_BYTES  = MEM_LINES * LINE_BYTES;

  logic                     clk;
  logic                     rst;
  logic                     valid;
  logic [DATA_WIDTH-1:0]    alu_result;
  logic [DATA_WIDTH-1:0]    rs2_data;
  logic [REG_IDX_WIDTH-1:0] wr_reg;
  logic                     reg_wr_en;
  logic                     is_load;
  logic                     is_store;
  access_size_t             access_size;
  logic [REG_IDX_WIDTH-1:0] rf_rd_addr;
  logic                     stall;
  logic [DATA_WIDTH-1:0]    rf_rd_data;
  logic                     rd_req_valid;
  logic                     wr_req_valid;

  logic [7:0]  shmem [MEM_BYTES];  // expected backing memory contents
  logic [31:0] shreg [32];
  string       last_writer [32];
  logic [31:0] lfsr_q = 32'he693_4d00;
  int          mismatches = 0;
  int          others = 0;
  int          cycles = 0;
  int          rd_count = 0;
  int          wr_count = 0;
  logic        rd_req_prev = 1'b0;
  logic        wr_req_prev = 1'b0;

  mem_wb_top u_mem_wb_top (
    .clk_i         (clk),
    .rst_i         (rst),
    .valid_i       (valid),
    .alu_result_i  (alu_result),
    .rs2_data_i    (rs2_data),
    .wr_reg_i      (wr_reg),
    .reg_wr_en_i   (reg_wr_en),
    .is_load_i     (is_load),
    .is_store_i    (is_store),
    .access_size_i (access_size),
    .rf_rd_addr_i  (rf_rd_addr),
    .stall_o       (stall),
    .rf_rd_data_o  (rf_rd_data),
    .rd_req_valid_o(rd_req_valid),
    .wr_req_valid_o(wr_req_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  // refills and writebacks counted on the rising edge of each request level
  always @(negedge clk) begin
    if (rst && rd_req_valid && !rd_req_prev) rd_count++;
    if (rst && wr_req_valid && !wr_req_prev) wr_count++;
    rd_req_prev = rd_req_valid;
    wr_req_prev = wr_req_valid;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("run stopped: instructions did not finish within %0d cycles", MAX_CYCLES);
      $display("%0d mismatches, %0d other errors", mismatches, others + 1);
      $display("Simulation failed");
      $finish;
    end
  end

  a_alu_no_stall: assert property (@(posedge clk) disable iff (!rst)
    valid && !is_load && !is_store |-> !stall)
    else begin
      others++;
      $display("non-memory instruction was stalled at %0t", $time);
    end

  // called at posedge+1, returns at posedge+1 after the completing edge
  task automatic issue(input mem_op_t op, input access_size_t size,
                       input logic [31:0] value, input logic [31:0] data,
                       input logic [4:0] rd);
    int          nbytes;
    logic [31:0] result;
    logic        done;
    nbytes = (size == BYTE) ? 1 : ((size == HALF) ? 2 : 4);
    result = value;
    if (op == OP_LOAD) begin
      result = '0;
      for (int b = 0; b < nbytes; b++) begin
        result[b*8 +: 8] = shmem[(value + b) % MEM_BYTES];  // zero-extended lane
      end
    end
    if (op == OP_STORE) begin
      for (int b = 0; b < nbytes; b++) begin
        shmem[(value + b) % MEM_BYTES] = data[b*8 +: 8];
      end
    end else if (rd != 0) begin
      shreg[rd] = result;
    end
    valid       = 1'b1;
    alu_result  = value;
    rs2_data    = data;
    wr_reg      = rd;
    reg_wr_en   = (op != OP_STORE);
    is_load     = (op == OP_LOAD);
    is_store    = (op == OP_STORE);
    access_size = size;
    done        = 1'b0;
    while (!done) begin
      @(negedge clk);
      done = !stall;
      @(posedge clk);
    end
    #1;
    valid = 1'b0;
  endtask

  task automatic check_reg(input string name, input int idx);
    rf_rd_addr = idx[4:0];
    @(negedge clk);
    assert (rf_rd_data === shreg[idx]) else begin
      mismatches++;
      $display("Mismatch %s x%0d: expected %h actual %h", name, idx, shreg[idx], rf_rd_data);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic load_check(input string name, input access_size_t size,
                            input logic [31:0] addr, input logic [4:0] rd);
    issue(OP_LOAD, size, addr, '0, rd);
    @(posedge clk);  // register file write lands one edge later
    #1;
    check_reg(name, rd);
  endtask

  task automatic check_count(input string name, input int expected, input int actual);
    assert (actual == expected) else begin
      mismatches++;
      $display("Mismatch %s: expected %0d actual %0d", name, expected, actual);
    end
  endtask

  initial begin
    mem_op_t      op;
    access_size_t size;
    logic [1:0]   kind;
    logic [1:0]   sz_bits;
    logic [31:0]  a;
    logic [31:0]  data;
    logic [4:0]   rd;
    int           rd_before;
    int           wr_before;
    rst         = 1'b0;
    valid       = 1'b0;
    alu_result  = '0;
    rs2_data    = '0;
    wr_reg      = '0;
    reg_wr_en   = 1'b0;
    is_load     = 1'b0;
    is_store    = 1'b0;
    access_size = WORD;
    rf_rd_addr  = '0;
    for (int i = 0; i < MEM_BYTES; i++) shmem[i] = 8'h00;
    for (int i = 0; i < 32; i++) begin
      shreg[i]       = '0;
      last_writer[i] = "reset";
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b1;

    @(negedge clk);
    assert (!stall && !rd_req_valid && !wr_req_valid) else begin
      others++;
      $display("stall or memory request active right after reset");
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < 32; i++) check_reg("reset", i);

    issue(OP_NONE, WORD, rand_bits(32), '0, 5'd1);
    issue(OP_NONE, WORD, rand_bits(32), '0, 5'd2);
    issue(OP_NONE, WORD, rand_bits(32), '0, 5'd0);  // x0 must stay zero
    issue(OP_NONE, WORD, rand_bits(32), '0, 5'd1);
    @(posedge clk);
    #1;
    check_reg("alu overwrite", 1);
    check_reg("alu write", 2);
    check_reg("alu to x0", 0);

    rd_before = rd_count;
    issue(OP_STORE, WORD, 32'h100, rand_bits(32), 5'd0);
    check_count("store cold miss refills", rd_before + 1, rd_count);
    rd_before = rd_count;
    load_check("word load hit", WORD, 32'h100, 5'd5);
    check_count("load hit refills", rd_before, rd_count);
    rd_before = rd_count;
    load_check("word load cold miss", WORD, 32'h118, 5'd6);
    check_count("load cold miss refills", rd_before + 1, rd_count);
    rd_before = rd_count;
    issue(OP_STORE, WORD, 32'h118, rand_bits(32), 5'd0);
    load_check("word load after store hit", WORD, 32'h118, 5'd7);
    check_count("store and load hit refills", rd_before, rd_count);

    issue(OP_STORE, WORD, 32'h120, rand_bits(32), 5'd0);
    issue(OP_STORE, BYTE, 32'h121, rand_bits(32), 5'd0);
    issue(OP_STORE, HALF, 32'h122, rand_bits(32), 5'd0);
    load_check("word after narrow stores", WORD, 32'h120, 5'd8);
    load_check("byte load lane 3", BYTE, 32'h123, 5'd9);
    load_check("half load lane 0", HALF, 32'h120, 5'd10);
    load_check("byte load lane 1", BYTE, 32'h121, 5'd11);

    // 0x130 and 0x170 share cache index 3
    issue(OP_STORE, WORD, 32'h130, rand_bits(32), 5'd0);
    wr_before = wr_count;
    issue(OP_STORE, WORD, 32'h170, rand_bits(32), 5'd0);
    check_count("dirty victim on store miss", wr_before + 1, wr_count);
    wr_before = wr_count;
    load_check("reload evicted line", WORD, 32'h130, 5'd12);
    check_count("dirty victim on load miss", wr_before + 1, wr_count);
    load_check("reload second line", WORD, 32'h170, 5'd13);

    for (int i = 0; i < N_RANDOM; i++) begin
      kind    = rand_bits(2);
      op      = (kind == 2'd1) ? OP_LOAD : ((kind == 2'd2) ? OP_STORE : OP_NONE);
      sz_bits = rand_bits(2);
      size    = (sz_bits == 2'd3) ? WORD : access_size_t'(sz_bits);
      a       = rand_bits(10);  // stay inside 1 KiB
      if (size == HALF) a[0] = 1'b0;
      if (size == WORD) a[1:0] = 2'b00;
      data    = rand_bits(32);
      rd      = rand_bits(5);
      if (op != OP_STORE) last_writer[rd] = $sformatf("random %s #%0d", op.name(), i);
      issue(op, size, (op == OP_NONE) ? data : a, data, rd);
    end
    repeat (2) @(posedge clk);
    #1;
    for (int i = 0; i < 32; i++) check_reg(last_writer[i], i);

    $display("%0d mismatches, %0d other errors", mismatches, others);
    if (mismatches == 0 && others == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_mem_wb

// File: rtl/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    valid_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]    alu_result_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]    rs2_data_i,
  input  logic [cpu_types_pkg::REG_IDX_WIDTH-1:0] wr_reg_i,
  input  logic                                    reg_wr_en_i,
  input  logic                                    is_load_i,
  input  logic                                    is_store_i,
  input  cpu_types_pkg::access_size_t             access_size_i,
  input  logic [cpu_types_pkg::REG_IDX_WIDTH-1:0] rf_rd_addr_i,
  output logic                                    stall_o,
  output logic [cache_cfg_pkg::DATA_WIDTH-1:0]    rf_rd_data_o,
  output logic                                    rd_req_valid_o,
  output logic                                    wr_req_valid_o
);
  import cache_cfg_pkg::*;
  import cpu_types_pkg::*;

  logic                     mem_req;
  logic                     mem_we;
  logic                     mem_gnt;
  logic                     mem_rvalid;
  logic [ADDR_WIDTH-1:0]    mem_addr;
  logic [LINE_WIDTH-1:0]    mem_wdata;
  logic [LINE_WIDTH-1:0]    mem_rdata;
  logic                     wb_valid;
  logic                     wb_reg_wr_en;
  logic [REG_IDX_WIDTH-1:0] wb_wr_reg;
  logic [DATA_WIDTH-1:0]    wb_data;

  assign rd_req_valid_o = mem_req && !mem_we;  // refill request
  assign wr_req_valid_o = mem_req && mem_we;   // victim writeback

  mem_stage u_mem_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (valid_i),
    .alu_result_i   (alu_result_i),
    .rs2_data_i     (rs2_data_i),
    .wr_reg_i       (wr_reg_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .is_load_i      (is_load_i),
    .is_store_i     (is_store_i),
    .access_size_i  (access_size_i),
    .mem_line_data_i(mem_rdata),
    .mem_rvalid_i   (mem_rvalid),
    .mem_gnt_i      (mem_gnt),
    .stall_o        (stall_o),
    .wb_valid_o     (wb_valid),
    .wb_reg_wr_en_o (wb_reg_wr_en),
    .wb_wr_reg_o    (wb_wr_reg),
    .wb_data_o      (wb_data),
    .mem_req_o      (mem_req),
    .mem_we_o       (mem_we),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata)
  );

  line_memory u_line_memory (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .gnt_o   (mem_gnt),
    .rvalid_o(mem_rvalid),
    .rdata_o (mem_rdata)
  );

  wb_stage u_wb_stage (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .wb_valid_i    (wb_valid),
    .wb_reg_wr_en_i(wb_reg_wr_en),
    .wb_wr_reg_i   (wb_wr_reg),
    .wb_data_i     (wb_data),
    .rf_rd_addr_i  (rf_rd_addr_i),
    .rf_rd_data_o  (rf_rd_data_o)
  );

endmodule : mem_wb_top

// File: rtl/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    wb_valid_i,
  input  logic                                    wb_reg_wr_en_i,
  input  logic [cpu_types_pkg::REG_IDX_WIDTH-1:0] wb_wr_reg_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]    wb_data_i,
  input  logic [cpu_types_pkg::REG_IDX_WIDTH-1:0] rf_rd_addr_i,
  output logic [cache_cfg_pkg::DATA_WIDTH-1:0]    rf_rd_data_o
);
  import cache_cfg_pkg::*;
  import cpu_types_pkg::*;

  logic                     valid_q;
  logic                     wr_en_q;
  logic [REG_IDX_WIDTH-1:0] wr_reg_q;
  logic [DATA_WIDTH-1:0]    data_q;
  logic [DATA_WIDTH-1:0]    rf_q [2**REG_IDX_WIDTH];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= wb_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_valid_i) begin
      wr_en_q  <= wb_reg_wr_en_i;
      wr_reg_q <= wb_wr_reg_i;
      data_q   <= wb_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < 2**REG_IDX_WIDTH; i++) begin
        rf_q[i] <= '0;
      end
    end else if (valid_q && wr_en_q && (wr_reg_q != '0)) begin
      rf_q[wr_reg_q] <= data_q;  // x0 is never written
    end
  end

  assign rf_rd_data_o = (rf_rd_addr_i == '0) ? '0 : rf_q[rf_rd_addr_i];

endmodule : wb_stage

// File: rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                                    clk_i,
  input  logic                                    rst_i,
  input  logic                                    valid_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]    alu_result_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]    rs2_data_i,
  input  logic [cpu_types_pkg::REG_IDX_WIDTH-1:0] wr_reg_i,
  input  logic                                    reg_wr_en_i,
  input  logic                                    is_load_i,
  input  logic                                    is_store_i,
  input  cpu_types_pkg::access_size_t             access_size_i,
  input  logic [cache_cfg_pkg::LINE_WIDTH-1:0]    mem_line_data_i,
  input  logic                                    mem_rvalid_i,
  input  logic                                    mem_gnt_i,
  output logic                                    stall_o,
  output logic                                    wb_valid_o,
  output logic                                    wb_reg_wr_en_o,
  output logic [cpu_types_pkg::REG_IDX_WIDTH-1:0] wb_wr_reg_o,
  output logic [cache_cfg_pkg::DATA_WIDTH-1:0]    wb_data_o,
  output logic                                    mem_req_o,
  output logic                                    mem_we_o,
  output logic [cache_cfg_pkg::ADDR_WIDTH-1:0]    mem_addr_o,
  output logic [cache_cfg_pkg::LINE_WIDTH-1:0]    mem_wdata_o
);
  import cache_cfg_pkg::*;
  import cpu_types_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    READY,
    WAITING
  } state_t;

  state_t  state_q, state_d;
  mem_op_t op;

  logic                    cache_req;
  logic                    cache_wr;
  logic                    cache_hit;
  logic                    cache_rvalid;
  logic [DATA_WIDTH-1:0]   cache_rdata;
  logic [DATA_WIDTH-1:0]   cache_wdata;
  logic [DATA_WIDTH/8-1:0] cache_wstrb;
  logic [DATA_WIDTH-1:0]   load_shifted;
  logic [DATA_WIDTH-1:0]   load_data;
  logic [1:0]              lane;

  assign op   = is_store_i ? OP_STORE : (is_load_i ? OP_LOAD : OP_NONE);
  assign lane = alu_result_i[1:0];

  data_cache #(
    .LINE_BYTES(LINE_BYTES),
    .N_LINES   (N_LINES)
  ) u_data_cache (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cpu_req_i   (cache_req),
    .cpu_wr_i    (cache_wr),
    .cpu_addr_i  (alu_result_i),
    .cpu_wdata_i (cache_wdata),
    .cpu_wstrb_i (cache_wstrb),
    .hit_o       (cache_hit),
    .cpu_rvalid_o(cache_rvalid),
    .cpu_rdata_o (cache_rdata),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rvalid_i(mem_rvalid_i),
    .mem_rdata_i (mem_line_data_i)
  );

  // narrow stores are replicated across the word, the strobe picks the lane
  assign load_shifted = cache_rdata >> {lane, 3'b000};

  always_comb begin
    case (access_size_i)
      BYTE: begin
        cache_wstrb = 4'b0001 << lane;
        cache_wdata = {4{rs2_data_i[7:0]}};
        load_data   = {24'b0, load_shifted[7:0]};
      end
      HALF: begin
        cache_wstrb = 4'b0011 << lane;
        cache_wdata = {2{rs2_data_i[15:0]}};
        load_data   = {16'b0, load_shifted[15:0]};
      end
      default: begin
        cache_wstrb = 4'b1111;
        cache_wdata = rs2_data_i;
        load_data   = load_shifted;
      end
    endcase
  end

  assign wb_wr_reg_o    = wr_reg_i;
  assign wb_data_o      = (op == OP_LOAD) ? load_data : alu_result_i;
  assign wb_reg_wr_en_o = wb_valid_o && reg_wr_en_i;

  always_comb begin
    state_d    = state_q;
    cache_req  = 1'b0;
    cache_wr   = 1'b0;
    wb_valid_o = 1'b0;
    stall_o    = 1'b0;
    case (state_q)
      IDLE: state_d = READY;
      READY: begin
        if (valid_i) begin
          case (op)
            OP_LOAD: begin
              cache_req = 1'b1;
              stall_o   = 1'b1;  // loads always wait for read data
              state_d   = WAITING;
            end
            OP_STORE: begin
              cache_req = 1'b1;
              cache_wr  = 1'b1;
              if (cache_hit) begin
                wb_valid_o = 1'b1;
              end else begin
                stall_o = 1'b1;
                state_d = WAITING;
              end
            end
            default: wb_valid_o = 1'b1;
          endcase
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        // a store miss is done once the refilled line hits
        if ((op == OP_LOAD && cache_rvalid) || (op == OP_STORE && cache_hit)) begin
          wb_valid_o = 1'b1;
          stall_o    = 1'b0;
          state_d    = READY;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
    stall_o |=> $stable({valid_i, alu_result_i, rs2_data_i, wr_reg_i, reg_wr_en_i,
                         is_load_i, is_store_i, access_size_i}))
    else $error("instruction changed while stalled");

  // the cycle after reset is IDLE and must not write back
  a_no_wb_in_idle: assert property (@(posedge clk_i) !rst_i |=> !wb_valid_o)
    else $error("writeback in IDLE");

endmodule : mem_stage

// File: rtl/line_memory.sv
`timescale 1ns/1ps

module line_memory #(
  parameter int READ_LATENCY = cache_cfg_pkg::MEM_READ_LATENCY
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 req_i,
  input  logic                                 we_i,
  input  logic [cache_cfg_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [cache_cfg_pkg::LINE_WIDTH-1:0] wdata_i,
  output logic                                 gnt_o,
  output logic                                 rvalid_o,
  output logic [cache_cfg_pkg::LINE_WIDTH-1:0] rdata_o
);
  import cache_cfg_pkg::*;

  localparam int OFF_W = $clog2(LINE_BYTES);
  localparam int IDX_W = $clog2(MEM_LINES);
  localparam int CNT_W = $clog2(READ_LATENCY + 1);

  logic [LINE_WIDTH-1:0] mem_q [MEM_LINES];
  logic                  gnt_q;
  logic                  busy_q;  // read in flight
  logic [CNT_W-1:0]      cnt_q;
  logic [IDX_W-1:0]      rd_idx_q;
  logic [IDX_W-1:0]      idx;

  assign idx      = addr_i[OFF_W +: IDX_W];  // upper address bits wrap
  assign gnt_o    = gnt_q;
  assign rvalid_o = busy_q && (cnt_q == '0);
  assign rdata_o  = mem_q[rd_idx_q];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      gnt_q  <= 1'b0;
      busy_q <= 1'b0;
      cnt_q  <= '0;
      for (int i = 0; i < MEM_LINES; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      gnt_q <= req_i && !busy_q && !gnt_q;  // one-cycle pulse per request
      if (gnt_q && we_i) begin
        mem_q[idx] <= wdata_i;
      end
      if (gnt_q && !we_i) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(READ_LATENCY - 1);
      end else if (busy_q) begin
        if (cnt_q == '0) begin
          busy_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_q && !we_i) begin
      rd_idx_q <= idx;
    end
  end

endmodule : line_memory

// File: rtl/data_cache.sv
`timescale 1ns/1ps

module data_cache #(
  parameter int LINE_BYTES = cache_cfg_pkg::LINE_BYTES,
  parameter int N_LINES    = cache_cfg_pkg::N_LINES
) (
  input  logic                                   clk_i,
  input  logic                                   rst_i,
  input  logic                                   cpu_req_i,
  input  logic                                   cpu_wr_i,
  input  logic [cache_cfg_pkg::ADDR_WIDTH-1:0]   cpu_addr_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH-1:0]   cpu_wdata_i,
  input  logic [cache_cfg_pkg::DATA_WIDTH/8-1:0] cpu_wstrb_i,
  output logic                                   hit_o,
  output logic                                   cpu_rvalid_o,
  output logic [cache_cfg_pkg::DATA_WIDTH-1:0]   cpu_rdata_o,
  output logic                                   mem_req_o,
  output logic                                   mem_we_o,
  output logic [cache_cfg_pkg::ADDR_WIDTH-1:0]   mem_addr_o,
  output logic [LINE_BYTES*8-1:0]                mem_wdata_o,
  input  logic                                   mem_gnt_i,
  input  logic                                   mem_rvalid_i,
  input  logic [LINE_BYTES*8-1:0]                mem_rdata_i
);
  import cache_cfg_pkg::*;

  localparam int LINE_W = LINE_BYTES * 8;
  localparam int WORD_B = DATA_WIDTH / 8;
  localparam int OFF_W  = $clog2(LINE_BYTES);
  localparam int IDX_W  = $clog2(N_LINES);
  localparam int TAG_W  = ADDR_WIDTH - OFF_W - IDX_W;
  localparam int WSEL_W = OFF_W - $clog2(WORD_B);

  typedef enum logic [2:0] {
    LOOKUP,
    WRITEBACK,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND
  } state_t;

  state_t state_q, state_d;

  logic [LINE_W-1:0]  data_q [N_LINES];
  logic [TAG_W-1:0]   tag_q  [N_LINES];
  logic [N_LINES-1:0] valid_q;
  logic [N_LINES-1:0] dirty_q;

  logic [ADDR_WIDTH-1:0] req_addr_q;  // request held until the miss is served
  logic                  req_wr_q;
  logic [DATA_WIDTH-1:0] req_wdata_q;
  logic [WORD_B-1:0]     req_wstrb_q;

  logic [IDX_W-1:0]  cpu_idx, req_idx;
  logic [TAG_W-1:0]  cpu_tag, req_tag;
  logic [WSEL_W-1:0] cpu_word, req_word;
  logic              store_hit;
  logic              refill_done;

  function automatic logic [LINE_W-1:0] merge_word(
    input logic [LINE_W-1:0]     line,
    input logic [WSEL_W-1:0]     word,
    input logic [DATA_WIDTH-1:0] wdata,
    input logic [WORD_B-1:0]     wstrb
  );
    logic [LINE_W-1:0] res;
    res = line;
    for (int b = 0; b < WORD_B; b++) begin
      if (wstrb[b]) begin
        res[(int'(word) * WORD_B + b) * 8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign cpu_idx  = cpu_addr_i[OFF_W +: IDX_W];
  assign cpu_tag  = cpu_addr_i[ADDR_WIDTH-1 -: TAG_W];
  assign cpu_word = cpu_addr_i[OFF_W-1 -: WSEL_W];
  assign req_idx  = req_addr_q[OFF_W +: IDX_W];
  assign req_tag  = req_addr_q[ADDR_WIDTH-1 -: TAG_W];
  assign req_word = req_addr_q[OFF_W-1 -: WSEL_W];

  assign hit_o        = valid_q[cpu_idx] && (tag_q[cpu_idx] == cpu_tag);
  assign store_hit    = (state_q == LOOKUP) && cpu_req_i && cpu_wr_i && hit_o;
  assign refill_done  = (state_q == REFILL_WAIT) && mem_rvalid_i;
  assign cpu_rvalid_o = (state_q == RESPOND) && !req_wr_q;  // stores complete through hit_o
  assign cpu_rdata_o  = data_q[req_idx][req_word*DATA_WIDTH +: DATA_WIDTH];
  assign mem_wdata_o  = data_q[req_idx];  // victim line during writeback

  always_comb begin
    state_d    = state_q;
    mem_req_o  = 1'b0;
    mem_we_o   = 1'b0;
    mem_addr_o = {req_tag, req_idx, {OFF_W{1'b0}}};
    case (state_q)
      LOOKUP: begin
        if (cpu_req_i && !hit_o) begin
          state_d = dirty_q[cpu_idx] ? WRITEBACK : REFILL_REQ;
        end else if (cpu_req_i && !cpu_wr_i) begin
          state_d = RESPOND;
        end
      end
      WRITEBACK: begin
        mem_req_o  = 1'b1;
        mem_we_o   = 1'b1;
        mem_addr_o = {tag_q[req_idx], req_idx, {OFF_W{1'b0}}};  // victim address
        if (mem_gnt_i) begin
          state_d = REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d = REFILL_WAIT;
        end
      end
      REFILL_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: state_d = LOOKUP;
      default: state_d = LOOKUP;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= LOOKUP;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state_q <= state_d;
      if (store_hit) begin
        dirty_q[cpu_idx] <= 1'b1;
      end
      if (state_q == WRITEBACK && mem_gnt_i) begin
        dirty_q[req_idx] <= 1'b0;
      end
      if (refill_done) begin
        valid_q[req_idx] <= 1'b1;
        dirty_q[req_idx] <= req_wr_q;  // a store miss leaves the line dirty
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == LOOKUP) && cpu_req_i) begin
      req_addr_q  <= cpu_addr_i;
      req_wr_q    <= cpu_wr_i;
      req_wdata_q <= cpu_wdata_i;
      req_wstrb_q <= cpu_wstrb_i;
    end
    if (store_hit) begin
      data_q[cpu_idx] <= merge_word(data_q[cpu_idx], cpu_word, cpu_wdata_i, cpu_wstrb_i);
    end
    if (refill_done) begin
      tag_q[req_idx]  <= req_tag;
      data_q[req_idx] <= merge_word(mem_rdata_i, req_word, req_wdata_q,
                                    req_wr_q ? req_wstrb_q : '0);
    end
  end

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o))
    else $error("memory request dropped before grant");

  // the line only comes back while a refill waits for it, never during a writeback
  a_rvalid_in_refill: assert property (@(posedge clk_i) disable iff (!rst_i)
    mem_rvalid_i |-> (state_q == REFILL_WAIT) && !mem_we_o)
    else $error("read data arrived outside a refill");

endmodule : data_cache

// File: rtl/cache_cfg_pkg.sv
package cache_cfg_pkg;

  localparam int ADDR_WIDTH       = 32;
  localparam int DATA_WIDTH       = 32;
  localparam int LINE_BYTES       = 16;
  localparam int LINE_WIDTH       = LINE_BYTES * 8;
  localparam int N_LINES          = 4;   // direct mapped
  localparam int MEM_LINES        = 64;  // backing store wraps at 1 KiB
  localparam int MEM_READ_LATENCY = 3;   // grant to read-valid

endpackage : cache_cfg_pkg

// File: rtl/cpu_types_pkg.sv
package cpu_types_pkg;

  localparam int REG_IDX_WIDTH = 5;  // 32 architectural registers

  // width of a load or store
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } access_size_t;

  // kind of access carried by an instruction in the memory stage
  typedef enum logic [1:0] {
    OP_NONE  = 2'b00,
    OP_LOAD  = 2'b01,
    OP_STORE = 2'b10
  } mem_op_t;

endpackage : cpu_types_pkg
